/* list.f */
+incdir+.
nf_if_pkg.sv
nf_if_reg_decode.sv
nf_if_reg_exec.sv
nf_if_reg_result.sv
nf_10g_if_regs.sv
nf_10g_if_regs_checker.sv
tb_nf_10g_if_regs.sv

/* Bender.yml */
package:
  name: nf_10g_if_regs

sources:
  - include_dirs:
      - .
    files:
      - nf_if_pkg.sv
      - nf_if_reg_decode.sv
      - nf_if_reg_exec.sv
      - nf_if_reg_result.sv
      - nf_10g_if_regs.sv
  - target: test
    include_dirs:
      - .
    files:
      - nf_10g_if_regs_checker.sv
      - tb_nf_10g_if_regs.sv

/* tb_nf_10g_if_regs.sv */
/*
 * Testbench for the 10G port register block.
 * APB register accesses, random stream traffic and packet counts.
 */

`timescale 1ns/100ps
`include "nf_if_cfg.svh"

module tb_nf_10g_if_regs;

  localparam nf_if_pkg::if_num_t IF_NUM = 16'h0005;
  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int TRAFFIC_CYCLES  = 400;
  localparam int TEST_CYCLES     = TRAFFIC_CYCLES + 600;  // Traffic plus register accesses
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic                 axi_aclk;
  logic                 resetn_sync;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  nf_if_pkg::reg_addr_t paddr;
  nf_if_pkg::reg_data_t pwdata;
  nf_if_pkg::reg_data_t prdata;
  logic                 pready;
  logic                 pslverr;
  logic                 s_axis_tvalid;
  logic                 s_axis_tready;
  logic                 s_axis_tlast;
  logic                 m_axis_tvalid;
  logic                 m_axis_tready;
  logic                 m_axis_tlast;

  integer               seed;
  nf_if_pkg::reg_data_t pkts_in;    // Accepted last beats, s_axis
  nf_if_pkg::reg_data_t pkts_out;   // Accepted last beats, m_axis
  nf_if_pkg::reg_data_t flip_val;
  nf_if_pkg::reg_data_t debug_val;

  nf_10g_if_regs #(
    .IF_NUMBER (IF_NUM)
  ) u_dut (
    .axi_aclk      (axi_aclk),
    .resetn_sync   (resetn_sync),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

  bind nf_10g_if_regs nf_10g_if_regs_checker u_checker (
    .axi_aclk    (axi_aclk),
    .resetn_sync (resetn_sync),
    .psel        (psel),
    .penable     (penable),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #(CLK_PERIOD / 2) axi_aclk = ~axi_aclk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge axi_aclk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////
  // Checks and bus tasks
  //////////////////////////////

  task automatic check_eq(input string name, input nf_if_pkg::reg_data_t exp,
                          input nf_if_pkg::reg_data_t act);
    assert (act === exp) else begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("Some tests failed");
      $fatal(1, "Value check failed");
    end
  endtask

  // Starts on a rising edge, returns on the edge after completion
  task automatic apb_xfer(input logic wr, input nf_if_pkg::reg_addr_t addr,
                          input nf_if_pkg::reg_data_t wdata,
                          output nf_if_pkg::reg_data_t rdata, output logic err);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge axi_aclk);
    penable <= 1'b1;
    @(posedge axi_aclk);
    while (!pready) @(posedge axi_aclk);
    rdata   = prdata;   // Values of the completion cycle
    err     = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(input string name, input nf_if_pkg::reg_addr_t addr,
                            input nf_if_pkg::reg_data_t exp, input logic exp_err);
    nf_if_pkg::reg_data_t rdata;
    logic                 err;
    apb_xfer(1'b0, addr, '0, rdata, err);
    check_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
    if (!exp_err) begin
      check_eq(name, exp, rdata);
    end
  endtask

  task automatic write_check(input string name, input nf_if_pkg::reg_addr_t addr,
                             input nf_if_pkg::reg_data_t data, input logic exp_err);
    nf_if_pkg::reg_data_t rdata;
    logic                 err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
  endtask

  // Random handshakes on both streams, counted on the driving edge
  task automatic run_traffic(input int cycles);
    logic [31:0] rnd;
    repeat (cycles) begin
      rnd = $random(seed);
      s_axis_tvalid <= rnd[0];
      s_axis_tready <= rnd[1];
      s_axis_tlast  <= rnd[2];
      m_axis_tvalid <= rnd[3];
      m_axis_tready <= rnd[4];
      m_axis_tlast  <= rnd[5];
      if (&rnd[2:0]) pkts_in = pkts_in + 1;
      if (&rnd[5:3]) pkts_out = pkts_out + 1;
      @(posedge axi_aclk);
    end
    s_axis_tvalid <= 1'b0;
    s_axis_tready <= 1'b0;
    s_axis_tlast  <= 1'b0;
    m_axis_tvalid <= 1'b0;
    m_axis_tready <= 1'b0;
    m_axis_tlast  <= 1'b0;
    @(posedge axi_aclk);  // Settle cycle
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed          = 32'h1689d5da;
    pkts_in       = '0;
    pkts_out      = '0;
    resetn_sync   = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tready = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    m_axis_tlast  = 1'b0;
    repeat (RESET_CYCLES) @(posedge axi_aclk);
    resetn_sync <= 1'b1;
    @(posedge axi_aclk);

    // Reset values
    read_check("reset ID", `NF_IF_OFS_ID, {IF_NUM, 16'hDA01}, 1'b0);
    read_check("reset VERSION", `NF_IF_OFS_VERSION, 32'h0100_0000, 1'b0);
    read_check("reset FLIP", `NF_IF_OFS_FLIP, 32'hFFFF_FFFF, 1'b0);
    read_check("reset DEBUG", `NF_IF_OFS_DEBUG, 32'h0000_0010, 1'b0);
    read_check("reset COUNTERIN", `NF_IF_OFS_COUNTERIN, '0, 1'b0);
    read_check("reset COUNTEROUT", `NF_IF_OFS_COUNTEROUT, '0, 1'b0);

    // FLIP and DEBUG, back to back
    flip_val  = $random(seed);
    debug_val = $random(seed);
    write_check("FLIP write", `NF_IF_OFS_FLIP, flip_val, 1'b0);
    read_check("FLIP readback", `NF_IF_OFS_FLIP, ~flip_val, 1'b0);
    write_check("DEBUG write", `NF_IF_OFS_DEBUG, debug_val, 1'b0);
    read_check("DEBUG readback", `NF_IF_OFS_DEBUG, debug_val + 32'h10, 1'b0);

    // Read only and unmapped offsets
    write_check("ID write", `NF_IF_OFS_ID, 32'hFFFF_FFFF, 1'b0);
    read_check("ID unchanged", `NF_IF_OFS_ID, {IF_NUM, 16'hDA01}, 1'b0);
    write_check("VERSION write", `NF_IF_OFS_VERSION, 32'h1234_5678, 1'b0);
    read_check("VERSION unchanged", `NF_IF_OFS_VERSION, 32'h0100_0000, 1'b0);
    read_check("read 0x18", 16'h0018, '0, 1'b1);
    write_check("write 0x18", 16'h0018, 32'hA5A5_A5A5, 1'b1);
    read_check("read 0x40", 16'h0040, '0, 1'b1);
    write_check("write 0x40", 16'h0040, 32'h5A5A_5A5A, 1'b1);
    read_check("FLIP at 0x0B", 16'h000B, ~flip_val, 1'b0);  // Low address bits ignored
    read_check("DEBUG after errors", `NF_IF_OFS_DEBUG, debug_val + 32'h10, 1'b0);

    // Packet counters
    run_traffic(TRAFFIC_CYCLES);
    read_check("COUNTERIN count", `NF_IF_OFS_COUNTERIN, pkts_in, 1'b0);
    read_check("COUNTEROUT count", `NF_IF_OFS_COUNTEROUT, pkts_out, 1'b0);

    write_check("COUNTERIN clear", `NF_IF_OFS_COUNTERIN, '0, 1'b0);
    pkts_in = '0;
    read_check("COUNTERIN cleared", `NF_IF_OFS_COUNTERIN, '0, 1'b0);
    read_check("COUNTEROUT kept", `NF_IF_OFS_COUNTEROUT, pkts_out, 1'b0);

    run_traffic(TRAFFIC_CYCLES / 4);
    write_check("COUNTEROUT clear", `NF_IF_OFS_COUNTEROUT, '0, 1'b0);
    pkts_out = '0;
    read_check("COUNTEROUT cleared", `NF_IF_OFS_COUNTEROUT, '0, 1'b0);
    read_check("COUNTERIN kept", `NF_IF_OFS_COUNTERIN, pkts_in, 1'b0);

    repeat (2) @(posedge axi_aclk);
    if (u_dut.u_checker.apb_err) begin
      $display("APB protocol assertion failed during the run");
      $display("Some tests failed");
      $fatal(1, "Protocol check failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

/* nf_10g_if_regs_checker.sv */
/*
 * APB protocol checker for the 10G port register block.
 * Bound to the top level, watches the one wait state completion.
 */

`timescale 1ns/100ps

module nf_10g_if_regs_checker (
  input logic axi_aclk,
  input logic resetn_sync,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr
);

  logic apb_err = 1'b0;  // Set by any failing assertion

  //////////////////////////////
  // Completion timing
  //////////////////////////////

  // First access cycle is the one where penable has just risen under psel
  a_ready_after_first: assert property (@(posedge axi_aclk) disable iff (!resetn_sync)
    psel && penable && !$past(penable) |=> pready)
    else begin
      $error("pready did not follow the first access cycle");
      apb_err = 1'b1;
    end

  a_ready_only_after_first: assert property (@(posedge axi_aclk) disable iff (!resetn_sync)
    pready |-> $past(psel && penable) && !$past(penable, 2))
    else begin
      $error("pready rose without a first access cycle before it");
      apb_err = 1'b1;
    end

  a_ready_single: assert property (@(posedge axi_aclk) disable iff (!resetn_sync)
    pready |=> !pready)
    else begin
      $error("pready stayed high for two cycles");
      apb_err = 1'b1;
    end

  //////////////////////////////
  // Response qualifiers
  //////////////////////////////

  a_err_with_ready: assert property (@(posedge axi_aclk) disable iff (!resetn_sync)
    pslverr |-> pready)
    else begin
      $error("pslverr high without pready");
      apb_err = 1'b1;
    end

  a_ready_needs_sel: assert property (@(posedge axi_aclk) disable iff (!resetn_sync)
    !psel |-> !pready)
    else begin
      $error("pready high while psel is low");
      apb_err = 1'b1;
    end

endmodule

/* nf_10g_if_regs.sv */
/*
 * Status and control registers of a 10G port, APB accessed.
 * Observes the host-to-port and port-to-host stream handshakes
 * and counts accepted packets on each.
 */

`timescale 1ns/100ps

module nf_10g_if_regs #(
  parameter nf_if_pkg::if_num_t IF_NUMBER = '0
) (
  input  logic                 axi_aclk,
  input  logic                 resetn_sync,
  // APB slave
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  nf_if_pkg::reg_addr_t paddr,
  input  nf_if_pkg::reg_data_t pwdata,
  output nf_if_pkg::reg_data_t prdata,
  output logic                 pready,
  output logic                 pslverr,
  // Stream taps
  input  logic                 s_axis_tvalid,
  input  logic                 s_axis_tready,
  input  logic                 s_axis_tlast,
  input  logic                 m_axis_tvalid,
  input  logic                 m_axis_tready,
  input  logic                 m_axis_tlast
);

  nf_if_pkg::reg_strobe_t wr_strobe;
  logic                   rd_en;
  nf_if_pkg::reg_idx_t    rd_idx;
  nf_if_pkg::reg_data_t   flip_q;
  nf_if_pkg::reg_data_t   debug_q;
  nf_if_pkg::reg_data_t   counterin_q;
  nf_if_pkg::reg_data_t   counterout_q;

  nf_if_reg_decode u_decode (
    .axi_aclk    (axi_aclk),
    .resetn_sync (resetn_sync),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .wr_strobe   (wr_strobe),
    .rd_en       (rd_en),
    .rd_idx      (rd_idx),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  nf_if_reg_exec u_exec (
    .axi_aclk      (axi_aclk),
    .resetn_sync   (resetn_sync),
    .wr_strobe     (wr_strobe),
    .pwdata        (pwdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tlast  (s_axis_tlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .flip_q        (flip_q),
    .debug_q       (debug_q),
    .counterin_q   (counterin_q),
    .counterout_q  (counterout_q)
  );

  nf_if_reg_result #(
    .IF_NUMBER (IF_NUMBER)
  ) u_result (
    .axi_aclk     (axi_aclk),
    .resetn_sync  (resetn_sync),
    .rd_en        (rd_en),
    .rd_idx       (rd_idx),
    .flip_q       (flip_q),
    .debug_q      (debug_q),
    .counterin_q  (counterin_q),
    .counterout_q (counterout_q),
    .prdata       (prdata)
  );

endmodule

/* nf_if_reg_result.sv */
/*
 * Read path of the port register block.
 * Forms each register's read value and latches the selected
 * one into the APB read data on a read pulse.
 */

`timescale 1ns/100ps
`include "nf_if_cfg.svh"

module nf_if_reg_result #(
  parameter nf_if_pkg::if_num_t IF_NUMBER = '0
) (
  input  logic                 axi_aclk,
  input  logic                 resetn_sync,
  input  logic                 rd_en,
  input  nf_if_pkg::reg_idx_t  rd_idx,
  input  nf_if_pkg::reg_data_t flip_q,
  input  nf_if_pkg::reg_data_t debug_q,
  input  nf_if_pkg::reg_data_t counterin_q,
  input  nf_if_pkg::reg_data_t counterout_q,
  output nf_if_pkg::reg_data_t prdata
);

  nf_if_pkg::reg_data_t rd_val;

  //////////////////////////////
  // Read mux
  //////////////////////////////

  always_comb begin
    case (rd_idx)
      `NF_IF_IDX(`NF_IF_OFS_ID):         rd_val = {IF_NUMBER, `NF_IF_ID_DEFAULT};
      `NF_IF_IDX(`NF_IF_OFS_VERSION):    rd_val = `NF_IF_VERSION_DEFAULT;
      `NF_IF_IDX(`NF_IF_OFS_FLIP):       rd_val = ~flip_q;
      `NF_IF_IDX(`NF_IF_OFS_COUNTERIN):  rd_val = counterin_q;
      `NF_IF_IDX(`NF_IF_OFS_COUNTEROUT): rd_val = counterout_q;
      `NF_IF_IDX(`NF_IF_OFS_DEBUG):      rd_val = `NF_IF_DEBUG_DEFAULT + debug_q;
      default:                           rd_val = '0;  // Never selected on rd_en
    endcase
  end

  //////////////////////////////
  // Read data register
  //////////////////////////////

  // Held until the next read, valid with pready
  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      prdata <= '0;
    end else if (rd_en) begin
      prdata <= rd_val;
    end
  end

endmodule

/* nf_if_reg_exec.sv */
/*
 * Register storage and packet counters of the port register block.
 * Holds the last FLIP and DEBUG writes and counts accepted packets
 * on the host-to-port and port-to-host streams.
 */

`timescale 1ns/100ps
`include "nf_if_cfg.svh"

module nf_if_reg_exec (
  input  logic                   axi_aclk,
  input  logic                   resetn_sync,
  input  nf_if_pkg::reg_strobe_t wr_strobe,
  input  nf_if_pkg::reg_data_t   pwdata,
  // Stream taps, observed only
  input  logic                   s_axis_tvalid,
  input  logic                   s_axis_tready,
  input  logic                   s_axis_tlast,
  input  logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  input  logic                   m_axis_tlast,
  output nf_if_pkg::reg_data_t   flip_q,
  output nf_if_pkg::reg_data_t   debug_q,
  output nf_if_pkg::reg_data_t   counterin_q,
  output nf_if_pkg::reg_data_t   counterout_q
);

  localparam int IDX_FLIP       = `NF_IF_IDX(`NF_IF_OFS_FLIP);
  localparam int IDX_COUNTERIN  = `NF_IF_IDX(`NF_IF_OFS_COUNTERIN);
  localparam int IDX_COUNTEROUT = `NF_IF_IDX(`NF_IF_OFS_COUNTEROUT);
  localparam int IDX_DEBUG      = `NF_IF_IDX(`NF_IF_OFS_DEBUG);

  logic [1:0]           pkt_done;   // 0 ingress, 1 egress
  logic [1:0]           cnt_clr;
  nf_if_pkg::reg_data_t cnt_q [2];

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  // ID and VERSION strobes have no storage here, read only
  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      flip_q  <= '0;
      debug_q <= '0;
    end else begin
      if (wr_strobe[IDX_FLIP]) begin
        flip_q <= pwdata;
      end
      if (wr_strobe[IDX_DEBUG]) begin
        debug_q <= pwdata;
      end
    end
  end

  //////////////////////////////
  // Packet counters
  //////////////////////////////

  // Accepted last beat ends a packet
  assign pkt_done[0] = s_axis_tvalid & s_axis_tready & s_axis_tlast;
  assign pkt_done[1] = m_axis_tvalid & m_axis_tready & m_axis_tlast;

  assign cnt_clr[0] = wr_strobe[IDX_COUNTERIN];
  assign cnt_clr[1] = wr_strobe[IDX_COUNTEROUT];

  for (genvar i = 0; i < 2; i++) begin : g_pkt_cnt
    always_ff @(posedge axi_aclk) begin
      if (!resetn_sync) begin
        cnt_q[i] <= '0;
      end else if (cnt_clr[i]) begin
        cnt_q[i] <= '0;             // Clear wins over a count
      end else if (pkt_done[i]) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;  // Wraps at 32 bits
      end
    end
  end

  assign counterin_q  = cnt_q[0];
  assign counterout_q = cnt_q[1];

endmodule

/* nf_if_reg_decode.sv */
/*
 * APB decode for the port register block.
 * Detects the first access cycle, maps the offset to a register
 * index and raises write strobes or a read pulse. Completes every
 * transfer with one wait state, flagging unmapped offsets.
 */

`timescale 1ns/100ps
`include "nf_if_cfg.svh"

module nf_if_reg_decode (
  input  logic                   axi_aclk,
  input  logic                   resetn_sync,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  nf_if_pkg::reg_addr_t   paddr,
  output nf_if_pkg::reg_strobe_t wr_strobe,
  output logic                   rd_en,
  output nf_if_pkg::reg_idx_t    rd_idx,
  output logic                   pready,
  output logic                   pslverr
);

  logic                       access_first;
  logic [`NF_IF_ADDR_W-3:0]   word_ofs;
  logic                       mapped;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign word_ofs = paddr[`NF_IF_ADDR_W-1:2];  // Bits 1:0 ignored
  assign mapped   = (word_ofs < `NF_IF_NUM_REGS);
  assign rd_idx   = nf_if_pkg::reg_idx_t'(word_ofs);

  //////////////////////////////
  // Access pulse and strobes
  //////////////////////////////

  // First cycle of the access phase only; the
  // completion cycle still has psel and penable high
  assign access_first = psel & penable & ~pready;

  assign rd_en = access_first & ~pwrite & mapped;

  always_comb begin
    wr_strobe = '0;
    if (access_first && pwrite && mapped) begin
      wr_strobe = nf_if_pkg::reg_strobe_t'(1) << rd_idx;  // One-hot
    end
  end

  //////////////////////////////
  // Completion, one wait state
  //////////////////////////////

  always_ff @(posedge axi_aclk) begin
    if (!resetn_sync) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else begin
      pready  <= access_first;
      pslverr <= access_first & ~mapped;  // Unmapped offset, no effect
    end
  end

endmodule

/* nf_if_pkg.sv */
/*
 * Shared vector types of the 10G port register block.
 * Used by the RTL and the testbench alike.
 */

`include "nf_if_cfg.svh"

package nf_if_pkg;

  // One register word, also the APB data width
  typedef logic [`NF_IF_DATA_W-1:0] reg_data_t;

  // APB address offset
  typedef logic [`NF_IF_ADDR_W-1:0] reg_addr_t;

  // Register index in map order, 0 to NUM_REGS-1
  typedef logic [$clog2(`NF_IF_NUM_REGS)-1:0] reg_idx_t;

  // One-hot write strobes, bit n for register n
  typedef logic [`NF_IF_NUM_REGS-1:0] reg_strobe_t;

  // Interface number, upper half of ID
  typedef logic [15:0] if_num_t;

endpackage

/* nf_if_cfg.svh */
/*
 * Register block configuration for the 10G port status unit.
 * Bus widths, register map offsets and reset/default values.
 */

`ifndef NF_IF_CFG_SVH
`define NF_IF_CFG_SVH

//////////////////////////////
// Widths
//////////////////////////////

`define NF_IF_DATA_W            32   // Register and APB data word
`define NF_IF_ADDR_W            16   // APB offset, no base address
`define NF_IF_NUM_REGS          6

//////////////////////////////
// Register map, byte offsets
//////////////////////////////

`define NF_IF_OFS_ID            16'h0000
`define NF_IF_OFS_VERSION       16'h0004
`define NF_IF_OFS_FLIP          16'h0008
`define NF_IF_OFS_COUNTERIN     16'h000C
`define NF_IF_OFS_COUNTEROUT    16'h0010
`define NF_IF_OFS_DEBUG         16'h0014

// Byte offset to register index in map order
`define NF_IF_IDX(ofs)          ((ofs) >> 2)

//////////////////////////////
// Default values
//////////////////////////////

`define NF_IF_ID_DEFAULT        16'hDA01        // Lower half of ID
`define NF_IF_VERSION_DEFAULT   32'h0100_0000
`define NF_IF_DEBUG_DEFAULT     32'h0000_0010   // Added to stored debug value

`endif
